// File: src/rvPkg.sv
`default_nettype none

package rvPkg;

    // Base opcodes, bits [6:0]
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // ALU operations
    localparam logic [3:0] ALU_ADD   = 4'b0000;
    localparam logic [3:0] ALU_SUB   = 4'b0001;
    localparam logic [3:0] ALU_SLL   = 4'b0010;
    localparam logic [3:0] ALU_SLT   = 4'b0011;
    localparam logic [3:0] ALU_SLTU  = 4'b0100;
    localparam logic [3:0] ALU_XOR   = 4'b0101;
    localparam logic [3:0] ALU_SRL   = 4'b0110;
    localparam logic [3:0] ALU_SRA   = 4'b0111;
    localparam logic [3:0] ALU_OR    = 4'b1000;
    localparam logic [3:0] ALU_AND   = 4'b1001;
    localparam logic [3:0] ALU_PASSB = 4'b1010; // lui
    localparam logic [3:0] ALU_NONE  = 4'b1111;

    // Write-back source (memToReg)
    localparam logic [1:0] WB_ALU   = 2'b00;
    localparam logic [1:0] WB_MEM   = 2'b01;
    localparam logic [1:0] WB_PC4   = 2'b10;
    localparam logic [1:0] WB_PCIMM = 2'b11;

    // Access length, value is bytes minus one
    localparam logic [1:0] LEN_BYTE = 2'b00;
    localparam logic [1:0] LEN_HALF = 2'b01;
    localparam logic [1:0] LEN_WORD = 2'b11;

    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    typedef union packed {
        struct packed {
            logic [6:0] funct7; // Also imm[11:5] of I type
            logic [4:0] rs2;    // Also imm[4:0] of I type
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } ri;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sb;
    } instrWord_u;

endpackage

`default_nettype wire

// File: src/ctrlIf.sv
`timescale 1ns/1ns
`default_nettype none

interface ctrlIf;
    logic [1:0]  memToReg;
    logic        memWrite;
    logic        branch;
    logic        jmp;        // jal or jalr
    logic        jalr;
    logic [3:0]  aluControl;
    logic        regWrite;
    logic [1:0]  dataLen;
    logic        dataSign;   // Signed load
    logic        aluSrc;     // 1 selects imm as operand B
    logic [2:0]  brCond;
    logic [31:0] imm;

    modport dec (output memToReg, memWrite, branch, jmp, jalr, aluControl, regWrite,
                 dataLen, dataSign, aluSrc, brCond, imm);
    modport exe (input aluControl, aluSrc, brCond, imm);
    modport pc  (input branch, jmp, jalr, imm);
    modport mem (input memToReg, memWrite, regWrite, dataLen, dataSign, imm);
endinterface

`default_nettype wire

// File: src/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  rvPkg::instrWord_u instr,
    output logic [4:0]        rs1Addr,
    output logic [4:0]        rs2Addr,
    output logic [4:0]        rdAddr,
    ctrlIf.dec                ctrl
);
    import rvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode  = instr.ri.opcode;
    assign funct3  = instr.ri.funct3;
    assign funct7  = instr.ri.funct7;
    assign rs1Addr = instr.ri.rs1;
    assign rs2Addr = instr.ri.rs2;
    assign rdAddr  = instr.ri.rd;

    // Single-bit controls straight off the opcode
    assign ctrl.memWrite = (opcode == OP_STORE);
    assign ctrl.branch   = (opcode == OP_BRANCH);
    assign ctrl.jmp      = (opcode == OP_JAL) || (opcode == OP_JALR);
    assign ctrl.jalr     = (opcode == OP_JALR);
    assign ctrl.aluSrc   = (opcode == OP_LOAD) || (opcode == OP_IMM) ||
                           (opcode == OP_LUI) || (opcode == OP_STORE);
    assign ctrl.brCond   = funct3;

    // Only lb and lh extend the sign
    assign ctrl.dataSign = (opcode == OP_LOAD) && (funct3[2:1] == 2'b00);

    always_comb begin
        case (funct3[1:0])
            2'b00:   ctrl.dataLen = LEN_BYTE;
            2'b01:   ctrl.dataLen = LEN_HALF;
            default: ctrl.dataLen = LEN_WORD;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_LOAD:  ctrl.memToReg = WB_MEM;
            OP_JAL,
            OP_JALR:  ctrl.memToReg = WB_PC4;    // Link value
            OP_AUIPC: ctrl.memToReg = WB_PCIMM;
            default:  ctrl.memToReg = WB_ALU;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_REG, OP_LOAD, OP_IMM, OP_JAL, OP_JALR, OP_LUI, OP_AUIPC: ctrl.regWrite = 1'b1;
            default: ctrl.regWrite = 1'b0;       // Includes unknown opcodes
        endcase
    end

    // ALU operation from opcode, funct3 and funct7
    always_comb begin
        ctrl.aluControl = ALU_NONE;
        if (opcode == OP_REG || opcode == OP_IMM) begin
            case (funct3)
                3'b000:  ctrl.aluControl = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  ctrl.aluControl = ALU_SLL;
                3'b010:  ctrl.aluControl = ALU_SLT;
                3'b011:  ctrl.aluControl = ALU_SLTU;
                3'b100:  ctrl.aluControl = ALU_XOR;
                3'b101:  ctrl.aluControl = funct7[5] ? ALU_SRA : ALU_SRL;  // srai via imm[10]
                3'b110:  ctrl.aluControl = ALU_OR;
                default: ctrl.aluControl = ALU_AND;
            endcase
        end else if (opcode == OP_LOAD || opcode == OP_STORE || opcode == OP_JALR) begin
            ctrl.aluControl = ALU_ADD;           // Address calculation
        end else if (opcode == OP_LUI) begin
            ctrl.aluControl = ALU_PASSB;
        end
    end

    // Immediate by format
    always_comb begin
        case (opcode)
            OP_STORE:
                ctrl.imm = {{20{instr.sb.immHi[6]}}, instr.sb.immHi, instr.sb.immLo};
            OP_BRANCH:
                ctrl.imm = {{19{instr.sb.immHi[6]}}, instr.sb.immHi[6], instr.sb.immLo[0],
                            instr.sb.immHi[5:0], instr.sb.immLo[4:1], 1'b0};
            OP_LUI, OP_AUIPC:
                ctrl.imm = {instr.ri.funct7, instr.ri.rs2, instr.ri.rs1, instr.ri.funct3,
                            12'b0};
            OP_JAL:
                ctrl.imm = {{11{instr.ri.funct7[6]}}, instr.ri.funct7[6], instr.ri.rs1,
                            instr.ri.funct3, instr.ri.rs2[0], instr.ri.funct7[5:0],
                            instr.ri.rs2[4:1], 1'b0};
            default:  // I type
                ctrl.imm = {{20{instr.ri.funct7[6]}}, instr.ri.funct7, instr.ri.rs2};
        endcase
    end

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data,
    input  logic        we,
    input  logic [4:0]  rdAddr,
    input  logic [31:0] rdData
);

    logic [31:0] regs [32];

    // Entry 0 is cleared at reset and never written
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = regs[rs1Addr]; // Asynchronous read
    assign rs2Data = regs[rs2Addr];

endmodule

`default_nettype wire

// File: src/aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
    ctrlIf.exe          ctrl,
    input  logic [31:0] rs1Data,
    input  logic [31:0] rs2Data,
    output logic [31:0] aluResult,
    output logic        brTaken
);
    import rvPkg::*;

    logic [31:0] opB;
    logic [4:0]  shamt;

    assign opB   = ctrl.aluSrc ? ctrl.imm : rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        case (ctrl.aluControl)
            ALU_ADD:   aluResult = rs1Data + opB;
            ALU_SUB:   aluResult = rs1Data - opB;
            ALU_SLL:   aluResult = rs1Data << shamt;
            ALU_SLT:   aluResult = {31'b0, $signed(rs1Data) < $signed(opB)};
            ALU_SLTU:  aluResult = {31'b0, rs1Data < opB};
            ALU_XOR:   aluResult = rs1Data ^ opB;
            ALU_SRL:   aluResult = rs1Data >> shamt;
            ALU_SRA:   aluResult = $unsigned($signed(rs1Data) >>> shamt);
            ALU_OR:    aluResult = rs1Data | opB;
            ALU_AND:   aluResult = rs1Data & opB;
            ALU_PASSB: aluResult = opB;
            default:   aluResult = '0;
        endcase
    end

    // Branch compare always uses the two registers
    always_comb begin
        case (ctrl.brCond)
            3'b000:  brTaken = (rs1Data == rs2Data);                   // beq
            3'b001:  brTaken = (rs1Data != rs2Data);                   // bne
            3'b100:  brTaken = ($signed(rs1Data) <  $signed(rs2Data)); // blt
            3'b101:  brTaken = ($signed(rs1Data) >= $signed(rs2Data)); // bge
            3'b110:  brTaken = (rs1Data <  rs2Data);                   // bltu
            3'b111:  brTaken = (rs1Data >= rs2Data);                   // bgeu
            default: brTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/pcUnit.sv
`timescale 1ns/1ns
`default_nettype none

module pcUnit (
    input  logic        clk,
    input  logic        rstN,
    input  logic        instrValid,
    ctrlIf.pc           ctrl,
    input  logic [31:0] rs1Data,
    input  logic        brTaken,
    output logic [31:0] pc
);

    logic [31:0] nextPc;
    logic [31:0] jalrTarget;

    assign jalrTarget = rs1Data + ctrl.imm;

    always_comb begin
        if (ctrl.jmp && ctrl.jalr) begin
            nextPc = {jalrTarget[31:1], 1'b0};
        end else if (ctrl.jmp || (ctrl.branch && brTaken)) begin
            nextPc = pc + ctrl.imm;  // jal or taken branch
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (instrValid) begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// File: src/loadStoreUnit.sv
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit (
    input  logic        clk,
    input  logic        instrValid,
    ctrlIf.mem          ctrl,
    input  logic [31:0] aluResult,
    input  logic [31:0] rs2Data,
    input  logic [31:0] pc,
    output logic [31:0] wbData,
    output logic        wbEn
);
    import rvPkg::*;

    logic [31:0]        mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] wordIdx;
    logic [1:0]         byteOff;
    logic [3:0]         byteEn;
    logic [31:0]        storeData;
    logic [31:0]        lane;       // Addressed data moved down to bit 0
    logic [31:0]        loadData;

    assign wordIdx = aluResult[DMEM_AW+1:2];
    assign byteOff = aluResult[1:0];

    // Lane enables and replicated store data
    always_comb begin
        case (ctrl.dataLen)
            LEN_BYTE: begin
                byteEn    = 4'b0001 << byteOff;
                storeData = {4{rs2Data[7:0]}};
            end
            LEN_HALF: begin
                byteEn    = 4'b0011 << {byteOff[1], 1'b0};
                storeData = {2{rs2Data[15:0]}};
            end
            default: begin
                byteEn    = 4'b1111;
                storeData = rs2Data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (instrValid && ctrl.memWrite) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) mem[wordIdx][i*8 +: 8] <= storeData[i*8 +: 8];
            end
        end
    end

    assign lane = mem[wordIdx] >> {byteOff, 3'b000};

    always_comb begin
        case (ctrl.dataLen)
            LEN_BYTE: loadData = {{24{ctrl.dataSign & lane[7]}}, lane[7:0]};
            LEN_HALF: loadData = {{16{ctrl.dataSign & lane[15]}}, lane[15:0]};
            default:  loadData = lane;
        endcase
    end

    always_comb begin
        case (ctrl.memToReg)
            WB_MEM:   wbData = loadData;
            WB_PC4:   wbData = pc + 32'd4;
            WB_PCIMM: wbData = pc + ctrl.imm;  // auipc
            default:  wbData = aluResult;
        endcase
    end

    assign wbEn = ctrl.regWrite && instrValid;

endmodule

`default_nettype wire

// File: src/rvCore.sv
`timescale 1ns/1ns
`default_nettype none

module rvCore (
    input  logic        clk,
    input  logic        rstN,
    input  logic        instrValid,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output logic        wbEn,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData
);

    logic [4:0]  rs1Addr;
    logic [4:0]  rs2Addr;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] aluResult;
    logic        brTaken;

    ctrlIf ctrlBus ();

    instrDecoder uInstrDecoder (
        .instr   (instr),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rdAddr  (wbAddr),
        .ctrl    (ctrlBus.dec)
    );

    regFile uRegFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .we      (wbEn),
        .rdAddr  (wbAddr),
        .rdData  (wbData)
    );

    aluUnit uAluUnit (
        .ctrl      (ctrlBus.exe),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .aluResult (aluResult),
        .brTaken   (brTaken)
    );

    pcUnit uPcUnit (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .ctrl       (ctrlBus.pc),
        .rs1Data    (rs1Data),
        .brTaken    (brTaken),
        .pc         (pc)
    );

    // Holds the data memory and drives the write-back ports
    loadStoreUnit uLoadStoreUnit (
        .clk        (clk),
        .instrValid (instrValid),
        .ctrl       (ctrlBus.mem),
        .aluResult  (aluResult),
        .rs2Data    (rs2Data),
        .pc         (pc),
        .wbData     (wbData),
        .wbEn       (wbEn)
    );

endmodule

`default_nettype wire

// File: dv/rvCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module rvCoreTb;
    import rvPkg::*;

    localparam int clkPeriod = 40;

    // Cycles per test, one for each issued instruction
    localparam int aluCycles    = 4 * (4 + 10);
    localparam int immCycles    = 2 * (2 + 6 + 3 + 2);
    localparam int memCycles    = 6 + 4 * 5 + 2 * 5 + 2;
    localparam int branchCycles = 4 * (4 + 6) + 2 + 2 + 1;
    localparam int miscCycles   = 7;
    localparam int resetCycles  = 5 + 4;  // Start-up reset and the reset test
    localparam int testCycles   = aluCycles + immCycles + memCycles + branchCycles +
                                  miscCycles + resetCycles;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;

    logic [31:0] regM [32];    // Register model
    logic [7:0]  memM [256];   // Byte model of the data memory
    logic [31:0] pcM;
    logic [31:0] seed = 32'h7769;
    int          checks = 0;
    int          errors = 0;
    int          issued = 0;

    rvCore dut0 (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .wbEn       (wbEn),
        .wbAddr     (wbAddr),
        .wbData     (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Instruction encoders
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // RV32I integer results by funct3 with alt selecting sub and sra
    function automatic logic [31:0] expectedOp(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkWb(input logic gotEn, input logic [4:0] gotAddr,
                           input logic expEn, input logic [4:0] expAddr);
        checks++;
        if (gotEn !== expEn) begin
            errors++;
            $display("MISMATCH wbEn got %h expected %h at %0t", gotEn, expEn, $time);
        end
        if (gotAddr !== expAddr) begin
            errors++;
            $display("MISMATCH wbAddr got %h expected %h at %0t", gotAddr, expAddr, $time);
        end
    endtask

    // One valid cycle with pc checked before the edge it changes on
    task automatic exec(input logic [31:0] w, input logic expEn, input logic [31:0] expVal,
                        input logic [31:0] nextPc);
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= w;
        @(negedge clk);
        checkWord("pc", pc, pcM);
        checkWb(wbEn, wbAddr, expEn, w[11:7]);
        if (expEn) checkWord("wbData", wbData, expVal);
        if (expEn && w[11:7] != 5'd0) regM[w[11:7]] = expVal;
        pcM = nextPc;
        issued++;
    endtask

    task automatic idleCycle(input logic [31:0] w);
        @(posedge clk);
        instrValid <= 1'b0;
        instr      <= w;
        @(negedge clk);
        checkWord("pc", pc, pcM);
        checkWb(wbEn, wbAddr, 1'b0, w[11:7]);
        issued++;
    endtask

    // lui and addi pair with hi rounded for the signed low part
    task automatic loadReg(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) >> 12;
        exec(uType(hi[19:0], rd, OP_LUI), 1'b1, {hi[19:0], 12'h000}, pcM + 4);
        exec(iType(v[11:0], rd, 3'd0, rd, OP_IMM), 1'b1, v, pcM + 4);
    endtask

    task automatic aluTests();
        logic [31:0] a;
        logic [31:0] b;
        for (int n = 0; n < 4; n++) begin
            a = nextRand();
            b = nextRand();
            if (n == 0) begin
                a = 32'd5;  // 5 - 9 goes negative
                b = 32'd9;
            end
            loadReg(1, a);
            loadReg(2, b);
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    if (alt == 1 && f3 != 0 && f3 != 5) continue;
                    exec(rType(alt == 1 ? 7'h20 : 7'h00, 2, 1, 3'(f3), 3), 1'b1,
                         expectedOp(3'(f3), 1'(alt), a, b), pcM + 4);
                end
            end
        end
    endtask

    task automatic immTests();
        logic [31:0] a;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [19:0] up;
        for (int n = 0; n < 2; n++) begin
            a   = nextRand();
            imm = 12'(nextRand() >> 20);
            loadReg(1, a);
            for (int k = 0; k < 8; k++) begin
                if (k == 1 || k == 5) continue;
                exec(iType(imm, 1, 3'(k), 3, OP_IMM), 1'b1,
                     expectedOp(3'(k), 1'b0, a, {{20{imm[11]}}, imm}), pcM + 4);
            end
            sh = 5'(nextRand() >> 16);
            exec(iType({7'h00, sh}, 1, 3'd1, 4, OP_IMM), 1'b1, a << sh, pcM + 4);
            exec(iType({7'h00, sh}, 1, 3'd5, 4, OP_IMM), 1'b1, a >> sh, pcM + 4);
            exec(iType({7'h20, sh}, 1, 3'd5, 4, OP_IMM), 1'b1,
                 $unsigned($signed(a) >>> sh), pcM + 4);
            up = 20'(nextRand() >> 12);
            exec(uType(up, 5, OP_LUI), 1'b1, {up, 12'h000}, pcM + 4);
            exec(uType(up, 6, OP_AUIPC), 1'b1, pcM + {up, 12'h000}, pcM + 4);
        end
    endtask

    // Base register is always x10
    task automatic storeOp(input logic [2:0] f3, input logic [4:0] rs2, input logic [11:0] off);
        logic [31:0] addr;
        addr = regM[10] + {{20{off[11]}}, off};
        exec(sType(off, rs2, 10, f3), 1'b0, 32'd0, pcM + 4);
        for (int i = 0; i < (1 << f3); i++) begin
            memM[addr[7:0] + 8'(i)] = regM[rs2][i*8 +: 8];
        end
    endtask

    task automatic loadOp(input logic [2:0] f3, input logic [11:0] off);
        logic [31:0] addr;
        logic [31:0] v;
        logic [31:0] exp;
        addr = regM[10] + {{20{off[11]}}, off};
        for (int i = 0; i < 4; i++) begin
            v[i*8 +: 8] = memM[addr[7:0] + 8'(i)];  // Bytes past the access go unused
        end
        case (f3)
            3'd0:    exp = {{24{v[7]}}, v[7:0]};
            3'd4:    exp = {24'd0, v[7:0]};
            3'd1:    exp = {{16{v[15]}}, v[15:0]};
            3'd5:    exp = {16'd0, v[15:0]};
            default: exp = v;
        endcase
        exec(iType(off, 10, f3, 13, OP_LOAD), 1'b1, exp, pcM + 4);
    endtask

    task automatic memTests();
        logic [31:0] v;
        loadReg(10, 32'h40);
        loadReg(11, nextRand());
        storeOp(3'd2, 11, 12'd0);
        storeOp(3'd2, 11, 12'd4);
        for (int off = 0; off < 4; off++) begin
            v    = nextRand();
            v[7] = off[0];  // Both signs of byte
            loadReg(12, v);
            storeOp(3'd0, 12, 12'(off));
            loadOp(3'd0, 12'(off));
            loadOp(3'd4, 12'(off));
        end
        for (int off = 4; off < 8; off += 2) begin
            v     = nextRand();
            v[15] = off[1];
            loadReg(12, v);
            storeOp(3'd1, 12, 12'(off));
            loadOp(3'd1, 12'(off));
            loadOp(3'd5, 12'(off));
        end
        loadOp(3'd2, 12'd0);
        loadOp(3'd2, 12'd4);
    endtask

    task automatic branchPair(input logic [31:0] a, input logic [31:0] b);
        logic [12:0] off;
        logic [31:0] target;
        loadReg(1, a);
        loadReg(2, b);
        for (int k = 0; k < 8; k++) begin
            if (k == 2 || k == 3) continue;
            off    = k[0] ? 13'h1FF8 : 13'd24;  // Back 8 or forward 24
            target = pcM + {{19{off[12]}}, off};
            exec(bType(off, 2, 1, 3'(k)), 1'b0, 32'd0,
                 branchTaken(3'(k), a, b) ? target : pcM + 4);
        end
    endtask

    task automatic branchTests();
        logic [31:0] v;
        v = nextRand();
        branchPair(v, v);
        branchPair(32'hFFFF_FFF0, 32'd5);   // Signed and unsigned order differ
        branchPair(32'd5, 32'hFFFF_FFF0);
        branchPair(nextRand(), nextRand());
        exec(jType(21'd64, 5), 1'b1, pcM + 4, pcM + 32'd64);
        exec(jType(21'h1FFFE0, 5), 1'b1, pcM + 4, pcM - 32'd32);
        loadReg(6, nextRand() | 32'd1);
        exec(iType(12'hFF7, 6, 3'd0, 7, OP_JALR), 1'b1, pcM + 4,
             (regM[6] + 32'hFFFF_FFF7) & ~32'd1);
    endtask

    task automatic miscTests();
        exec(iType(12'd5, 0, 3'd0, 0, OP_IMM), 1'b1, 32'd5, pcM + 4);
        exec(iType(12'd0, 0, 3'd0, 7, OP_IMM), 1'b1, 32'd0, pcM + 4);  // x0 still zero
        loadReg(8, nextRand());
        exec(iType(12'h123, 1, 3'd0, 8, 7'b0001011), 1'b0, 32'd0, pcM + 4);  // Custom-0
        idleCycle(iType(12'd1, 0, 3'd0, 8, OP_IMM));
        exec(iType(12'd0, 8, 3'd0, 9, OP_IMM), 1'b1, regM[8], pcM + 4);
    endtask

    task automatic resetTest();
        @(posedge clk);
        rstN       <= 1'b0;
        instrValid <= 1'b0;
        @(negedge clk);
        checkWord("pc", pc, 32'd0);
        checkWb(wbEn, wbAddr, 1'b0, instr[11:7]);
        @(posedge clk);
        rstN <= 1'b1;
        pcM = 32'd0;
        for (int i = 0; i < 32; i++) regM[i] = 32'd0;
        exec(iType(12'd0, 1, 3'd0, 9, OP_IMM), 1'b1, 32'd0, pcM + 4);
        idleCycle(iType(12'd0, 0, 3'd0, 0, OP_IMM));
    endtask

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = 32'd0;
        pcM        = 32'd0;
        for (int i = 0; i < 32; i++) regM[i] = 32'd0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkWord("pc", pc, 32'd0);
        checkWb(wbEn, wbAddr, 1'b0, 5'd0);
        @(posedge clk);
        rstN <= 1'b1;
        aluTests();
        immTests();
        memTests();
        branchTests();
        miscTests();
        resetTest();
        $display("Summary: %0d instructions, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((testCycles + 20) * clkPeriod);
        $display("Timeout: the tests did not finish after %0d instructions", issued);
        $display("Summary: %0d instructions, %0d checks, %0d errors", issued, checks, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
src/rvPkg.sv
src/ctrlIf.sv
src/instrDecoder.sv
src/regFile.sv
src/aluUnit.sv
src/pcUnit.sv
src/loadStoreUnit.sv
src/rvCore.sv
dv/rvCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the rvCore testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f vlog.f --top-module rvCoreTb --Mdir obj_dir -o simv \
    && ./obj_dir/simv > sim.log \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0
